//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/bimodal_table.sv
`timescale 1ns/1ps
`default_nettype none

module bimodal_table (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [bpu_pkg::BIM_IDX_W-1:0]     rd_idx_i,
    output logic                             taken_o,
    input  wire                              wr_en_i,
    input  wire [bpu_pkg::BIM_IDX_W-1:0]     wr_idx_i,
    input  wire                              wr_taken_i
);

    logic [1:0] ctr_q [bpu_pkg::BIM_ENTRIES];

    assign taken_o = ctr_q[rd_idx_i][1];  // msb is the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx_i] <= bpu_pkg::ctr_update(ctr_q[wr_idx_i], wr_taken_i);
        end
    end

    // counter must saturate, never wrap to the opposite end
    assert property (
        @(posedge clk) disable iff (rst)
        wr_en_i |=> ctr_q[$past(wr_idx_i)] !=
            ($past(wr_taken_i) ? bpu_pkg::CTR_STRONG_NT : bpu_pkg::CTR_STRONG_T)
    ) else $error("bimodal counter wrapped at index %0d", $past(wr_idx_i));

endmodule

`default_nettype wire

//--- hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int XLEN     = 32;
    localparam int HIST_LEN = 16;

    localparam int BIM_ENTRIES = 256;
    localparam int BIM_IDX_W   = 8;     // pc[9:2]
    localparam int TAG_ENTRIES = 64;
    localparam int TAG_IDX_W   = 6;
    localparam int TAG_W       = 10;
    localparam int PTAG_W      = 6;     // upper tag bits compared on lookup
    localparam int BTB_ENTRIES = 64;
    localparam int BTB_IDX_W   = 6;     // pc[7:2]
    localparam int BTB_TAG_W   = 24;    // pc[31:8]

    // hash slices
    localparam int PC_IDX_LSB      = 2;
    localparam int PC_TAG_LSB      = 8;  // pc[17:8] feeds both tag hashes
    localparam int T0_IDX_HIST_LSB = 0;  // hist[5:0]
    localparam int T1_IDX_HIST_LSB = 8;  // hist[13:8]
    localparam int T0_TAG_HIST_LSB = 6;  // hist[15:6]
    localparam int T1_TAG_HIST_W   = 8;  // hist[7:0], zero extended

    localparam logic [1:0] CTR_STRONG_NT = 2'd0;
    localparam logic [1:0] CTR_WEAK_NT   = 2'd1;
    localparam logic [1:0] CTR_WEAK_T    = 2'd2;
    localparam logic [1:0] CTR_STRONG_T  = 2'd3;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1,
        PROV_T1  = 2'd2
    } provider_e;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_TRAIN = 2'd1,   // saturate toward outcome
        CMD_RESET = 2'd2,   // force strong toward outcome
        CMD_ALLOC = 2'd3    // claim entry with new tag
    } tag_cmd_e;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_req_t;

    typedef struct packed {
        logic            is_ctrl;
        logic            taken;
        logic [XLEN-1:0] target;
        provider_e       provider;
    } bp_pred_t;

    typedef struct packed {
        logic                valid;
        logic                taken;
        logic                correct;
        provider_e           provider;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     target;
        logic [HIST_LEN-1:0] history;  // snapshot taken at prediction time
    } bp_update_t;

    // 2-bit saturating step
    function automatic logic [1:0] ctr_update(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == CTR_STRONG_T) ? ctr : ctr + 2'd1;
        end
        return (ctr == CTR_STRONG_NT) ? ctr : ctr - 2'd1;
    endfunction

endpackage

`default_nettype wire

//--- hw/bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire                              clk,
    input  wire                              rst,
    input  var bpu_pkg::fetch_req_t          fetch_i,
    input  var bpu_pkg::bp_update_t          update_i,
    output bpu_pkg::bp_pred_t                pred_o,
    output logic [bpu_pkg::HIST_LEN-1:0]     history_o
);

    logic                       is_branch, is_jal;
    logic [bpu_pkg::XLEN-1:0]   imm_target;
    logic                       dir_taken;
    bpu_pkg::provider_e         provider;
    logic                       btb_hit;
    logic [bpu_pkg::XLEN-1:0]   btb_target;

    inst_predecode u_predecode (
        .fetch_i      (fetch_i),
        .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),
        .imm_target_o (imm_target)
    );

    tage_direction u_tage (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (fetch_i.pc),
        .update_i   (update_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history_o)   // snapshot goes back with the update
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_i.pc),
        .hit_o    (btb_hit),
        .target_o (btb_target),
        .update_i (update_i)
    );

    next_pc_select u_select (
        .fetch_i      (fetch_i),
        .is_branch_i  (is_branch),
        .is_jal_i     (is_jal),
        .imm_target_i (imm_target),
        .dir_taken_i  (dir_taken),
        .provider_i   (provider),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

//--- hw/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [bpu_pkg::XLEN-1:0]      pc_i,
    output logic                         hit_o,
    output logic [bpu_pkg::XLEN-1:0]     target_o,
    input  var bpu_pkg::bp_update_t      update_i
);

    logic                            valid_q  [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_TAG_W-1:0]   tag_q    [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0]        target_q [bpu_pkg::BTB_ENTRIES];

    logic [bpu_pkg::BTB_IDX_W-1:0]   rd_idx, wr_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0]   rd_tag, wr_tag;
    logic                            wr_en;

    assign rd_idx = pc_i[bpu_pkg::PC_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign rd_tag = pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
    assign wr_idx = update_i.pc[bpu_pkg::PC_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign wr_tag = update_i.pc[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
    assign wr_en  = update_i.valid && update_i.taken;  // only taken outcomes fill

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= update_i.target;
        end
    end

    // a fetch of the pc just written sees the new entry right after the edge
    assert property (@(posedge clk) disable iff (rst)
        wr_en |=> (pc_i != $past(update_i.pc)) ||
                  (hit_o && (target_o == $past(update_i.target)))
    ) else $error("btb entry for pc %h not visible after taken update", $past(update_i.pc));

endmodule

`default_nettype wire

//--- hw/inst_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_predecode (
    input  var bpu_pkg::fetch_req_t         fetch_i,
    output logic                            is_branch_o,
    output logic                            is_jal_o,
    output logic [bpu_pkg::XLEN-1:0]        imm_target_o
);

    bpu_pkg::inst_u            word;
    logic [bpu_pkg::XLEN-1:0]  b_imm;
    logic [bpu_pkg::XLEN-1:0]  j_imm;

    assign word = fetch_i.inst;

    // opcode sits at the same place in both views
    assign is_branch_o = (word.b.opcode == bpu_pkg::OPC_BRANCH);
    assign is_jal_o    = (word.j.opcode == bpu_pkg::OPC_JAL);

    assign b_imm = {
        {20{word.b.imm12}},   // sign
        word.b.imm11,
        word.b.imm10_5,
        word.b.imm4_1,
        1'b0
    };

    assign j_imm = {
        {12{word.j.imm20}},
        word.j.imm19_12,
        word.j.imm11,
        word.j.imm10_1,
        1'b0
    };

    // only meaningful for branch/jal, next_pc_select ignores it otherwise
    assign imm_target_o = fetch_i.pc + (is_jal_o ? j_imm : b_imm);

endmodule

`default_nettype wire

//--- hw/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  var bpu_pkg::fetch_req_t      fetch_i,
    input  wire                          is_branch_i,
    input  wire                          is_jal_i,
    input  wire [bpu_pkg::XLEN-1:0]      imm_target_i,
    input  wire                          dir_taken_i,
    input  var bpu_pkg::provider_e       provider_i,
    input  wire                          btb_hit_i,
    input  wire [bpu_pkg::XLEN-1:0]      btb_target_i,
    output bpu_pkg::bp_pred_t            pred_o
);

    logic [bpu_pkg::XLEN-1:0] taken_target;

    // btb beats the decoded immediate
    assign taken_target = btb_hit_i ? btb_target_i : imm_target_i;

    always_comb begin
        pred_o.is_ctrl  = 1'b0;
        pred_o.taken    = 1'b0;
        pred_o.target   = fetch_i.pc + 32'd4;  // fall through
        pred_o.provider = bpu_pkg::PROV_BIM;
        if (is_jal_i) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = 1'b1;
            pred_o.target  = taken_target;
        end else if (is_branch_i) begin
            pred_o.is_ctrl  = 1'b1;
            pred_o.taken    = dir_taken_i;
            pred_o.provider = provider_i;
            if (dir_taken_i) begin
                pred_o.target = taken_target;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tage_direction.sv
`timescale 1ns/1ps
`default_nettype none

module tage_direction (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [bpu_pkg::XLEN-1:0]          pc_i,
    input  var bpu_pkg::bp_update_t          update_i,
    output logic                             taken_o,
    output bpu_pkg::provider_e               provider_o,
    output logic [bpu_pkg::HIST_LEN-1:0]     history_o
);

    logic [bpu_pkg::HIST_LEN-1:0] history_q;

    logic [bpu_pkg::TAG_IDX_W-1:0] t0_rd_idx, t1_rd_idx, t0_wr_idx, t1_wr_idx;
    logic [bpu_pkg::TAG_W-1:0]     t0_rd_tag, t1_rd_tag, t0_wr_tag, t1_wr_tag;
    logic                          t0_hit, t1_hit, t0_taken, t1_taken, bim_taken;
    logic                          t1_differs;
    bpu_pkg::tag_cmd_e             t0_cmd, t1_cmd;

    function automatic logic [bpu_pkg::TAG_IDX_W-1:0] idx_hash(
        input logic [bpu_pkg::XLEN-1:0]     pc,
        input logic [bpu_pkg::HIST_LEN-1:0] hist,
        input int                           hlsb
    );
        return pc[bpu_pkg::PC_IDX_LSB +: bpu_pkg::TAG_IDX_W] ^ hist[hlsb +: bpu_pkg::TAG_IDX_W];
    endfunction

    function automatic logic [bpu_pkg::TAG_W-1:0] t0_tag_hash(
        input logic [bpu_pkg::XLEN-1:0]     pc,
        input logic [bpu_pkg::HIST_LEN-1:0] hist
    );
        return pc[bpu_pkg::PC_TAG_LSB +: bpu_pkg::TAG_W] ^
               hist[bpu_pkg::T0_TAG_HIST_LSB +: bpu_pkg::TAG_W];
    endfunction

    function automatic logic [bpu_pkg::TAG_W-1:0] t1_tag_hash(
        input logic [bpu_pkg::XLEN-1:0]     pc,
        input logic [bpu_pkg::HIST_LEN-1:0] hist
    );
        return pc[bpu_pkg::PC_TAG_LSB +: bpu_pkg::TAG_W] ^
               {{(bpu_pkg::TAG_W - bpu_pkg::T1_TAG_HIST_W){1'b0}},
                hist[bpu_pkg::T1_TAG_HIST_W-1:0]};
    endfunction

    // lookup uses live history, update uses the returned snapshot
    assign t0_rd_idx = idx_hash(pc_i, history_q, bpu_pkg::T0_IDX_HIST_LSB);
    assign t1_rd_idx = idx_hash(pc_i, history_q, bpu_pkg::T1_IDX_HIST_LSB);
    assign t0_rd_tag = t0_tag_hash(pc_i, history_q);
    assign t1_rd_tag = t1_tag_hash(pc_i, history_q);
    assign t0_wr_idx = idx_hash(update_i.pc, update_i.history, bpu_pkg::T0_IDX_HIST_LSB);
    assign t1_wr_idx = idx_hash(update_i.pc, update_i.history, bpu_pkg::T1_IDX_HIST_LSB);
    assign t0_wr_tag = t0_tag_hash(update_i.pc, update_i.history);
    assign t1_wr_tag = t1_tag_hash(update_i.pc, update_i.history);

    // longest history wins
    always_comb begin
        if (t1_hit) begin
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = t1_taken;
        end else if (t0_hit) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = t0_taken;
        end else begin
            provider_o = bpu_pkg::PROV_BIM;
            taken_o    = bim_taken;
        end
    end

    always_comb begin
        t0_cmd = bpu_pkg::CMD_NONE;
        t1_cmd = bpu_pkg::CMD_NONE;
        if (update_i.valid) begin
            case (update_i.provider)
                bpu_pkg::PROV_T0: t0_cmd = update_i.correct ? bpu_pkg::CMD_TRAIN : bpu_pkg::CMD_RESET;
                bpu_pkg::PROV_T1: t1_cmd = update_i.correct ? bpu_pkg::CMD_TRAIN : bpu_pkg::CMD_RESET;
                default: begin
                    if (!update_i.correct) begin  // bimodal mispredict allocates
                        if (t1_differs) t1_cmd = bpu_pkg::CMD_ALLOC;
                        else            t0_cmd = bpu_pkg::CMD_ALLOC;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history_q <= '0;
        end else if (update_i.valid) begin
            history_q <= {history_q[bpu_pkg::HIST_LEN-2:0], update_i.taken};
        end
    end

    assign history_o = history_q;

    bimodal_table bim_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (pc_i[bpu_pkg::PC_IDX_LSB +: bpu_pkg::BIM_IDX_W]),
        .taken_o    (bim_taken),
        .wr_en_i    (update_i.valid),  // always trains
        .wr_idx_i   (update_i.pc[bpu_pkg::PC_IDX_LSB +: bpu_pkg::BIM_IDX_W]),
        .wr_taken_i (update_i.taken)
    );

    tagged_table t0_table (
        .clk (clk), .rst (rst),
        .rd_idx_i (t0_rd_idx), .rd_tag_i (t0_rd_tag), .hit_o (t0_hit), .taken_o (t0_taken),
        .cmd_i (t0_cmd), .wr_idx_i (t0_wr_idx), .wr_tag_i (t0_wr_tag),
        .wr_taken_i (update_i.taken), .tag_differs_o ()
    );

    tagged_table t1_table (
        .clk (clk), .rst (rst),
        .rd_idx_i (t1_rd_idx), .rd_tag_i (t1_rd_tag), .hit_o (t1_hit), .taken_o (t1_taken),
        .cmd_i (t1_cmd), .wr_idx_i (t1_wr_idx), .wr_tag_i (t1_wr_tag),
        .wr_taken_i (update_i.taken), .tag_differs_o (t1_differs)
    );

endmodule

`default_nettype wire

//--- hw/tagged_table.sv
`timescale 1ns/1ps
`default_nettype none

module tagged_table (
    input  wire                              clk,
    input  wire                              rst,
    // lookup
    input  wire [bpu_pkg::TAG_IDX_W-1:0]     rd_idx_i,
    input  wire [bpu_pkg::TAG_W-1:0]         rd_tag_i,
    output logic                             hit_o,
    output logic                             taken_o,
    // update
    input  var bpu_pkg::tag_cmd_e            cmd_i,
    input  wire [bpu_pkg::TAG_IDX_W-1:0]     wr_idx_i,
    input  wire [bpu_pkg::TAG_W-1:0]         wr_tag_i,
    input  wire                              wr_taken_i,
    output logic                             tag_differs_o
);

    localparam int PT_LSB = bpu_pkg::TAG_W - bpu_pkg::PTAG_W;

    logic                        valid_q [bpu_pkg::TAG_ENTRIES];
    logic [bpu_pkg::TAG_W-1:0]   tag_q   [bpu_pkg::TAG_ENTRIES];
    logic [1:0]                  ctr_q   [bpu_pkg::TAG_ENTRIES];

    // partial match on the upper tag bits only
    assign hit_o   = valid_q[rd_idx_i] &&
                     (tag_q[rd_idx_i][bpu_pkg::TAG_W-1:PT_LSB] == rd_tag_i[bpu_pkg::TAG_W-1:PT_LSB]);
    assign taken_o = ctr_q[rd_idx_i][1];

    // an empty slot counts as a different tag
    assign tag_differs_o = !valid_q[wr_idx_i] || (tag_q[wr_idx_i] != wr_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::TAG_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (cmd_i == bpu_pkg::CMD_ALLOC) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (cmd_i)
            bpu_pkg::CMD_TRAIN: ctr_q[wr_idx_i] <= bpu_pkg::ctr_update(ctr_q[wr_idx_i], wr_taken_i);
            bpu_pkg::CMD_RESET: begin
                ctr_q[wr_idx_i] <= wr_taken_i ? bpu_pkg::CTR_STRONG_T : bpu_pkg::CTR_STRONG_NT;
            end
            bpu_pkg::CMD_ALLOC: begin
                tag_q[wr_idx_i] <= wr_tag_i;
                ctr_q[wr_idx_i] <= wr_taken_i ? bpu_pkg::CTR_WEAK_T : bpu_pkg::CTR_WEAK_NT;
            end
            default: ;
        endcase
    end

    // training only follows a prediction this table provided
    assert property (@(posedge clk) disable iff (rst)
        (cmd_i == bpu_pkg::CMD_TRAIN) |-> valid_q[wr_idx_i]
    ) else $error("train command on invalid entry %0d", wr_idx_i);

endmodule

`default_nettype wire

//--- src.f
hw/bpu_pkg.sv
hw/inst_predecode.sv
hw/bimodal_table.sv
hw/tagged_table.sv
hw/btb.sv
hw/next_pc_select.sv
hw/tage_direction.sv
hw/bpu_top.sv
verification/tb_bpu.sv

//--- verification/bpu_cases.txt
# L pc inst exp_is_ctrl exp_taken exp_target exp_provider (0 bim, 1 t0, 2 t1), hex pc/inst/target
# U pc taken correct provider target; an L with exp_is_ctrl 0 gets a random pc, target pc+4
# non-control words: addi, lw, jalr
L 00000000 00100093 0 0 00000000 0
L 00000000 0000a103 0 0 00000000 0
L 00000000 000080e7 0 0 00000000 0
# jal with btb miss
L 00001000 1000006f 1 1 00001100 0
L 00002010 ff9ff06f 1 1 00002008 0
# branches right after reset
L 00000440 00000863 1 0 00000444 0
L 00000880 fe209ee3 1 0 00000884 0
# taken bimodal miss allocates t1 weak taken and fills btb
U 00000440 1 0 0 00000450
L 00000440 00000863 1 1 00000450 2
# jal redirected through btb
U 00001000 1 1 0 00003000
L 00001000 1000006f 1 1 00003000 0
L 00000880 fe209ee3 1 0 00000884 0
U 00000880 0 1 0 0000087c
L 00000880 fe209ee3 1 0 00000884 0
U 00000880 1 0 0 0000087c
L 00000880 fe209ee3 1 1 0000087c 2
# t1 mispredict, new history misses the partial tag
U 00000880 0 0 2 0000087c
L 00000880 fe209ee3 1 0 00000884 0
L 00002010 ff9ff06f 1 1 00002008 0
L 00000000 00100093 0 0 00000000 0
L 00000000 0000a103 0 0 00000000 0
L 00000440 00000863 1 1 00000450 0

//--- verification/tb_bpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bpu;

    localparam int    MAX_CASES = 64;
    localparam string CASE_FILE = "verification/bpu_cases.txt";

    typedef struct packed {
        logic [7:0]  kind;      // L or U
        logic [31:0] pc;
        logic [31:0] inst;
        logic        flag_a;    // lookup: is_ctrl, update: taken
        logic        flag_b;    // lookup: taken, update: correct
        logic [1:0]  prov;
        logic [31:0] target;
    } case_t;

    logic                          clk;
    logic                          rst;
    bpu_pkg::fetch_req_t           fetch_i;
    bpu_pkg::bp_update_t           update_i;
    bpu_pkg::bp_pred_t             pred_o;
    logic [bpu_pkg::HIST_LEN-1:0]  history_o;

    case_t                         cases [MAX_CASES];
    int                            n_cases;
    int                            errors;
    int                            checks;
    int                            cycle_count;
    int                            cycle_limit;
    int                            seed;
    bit                            load_ok;
    logic [bpu_pkg::HIST_LEN-1:0]  hist_model;  // expected global history

    bpu_top uut (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch_i),
        .update_i  (update_i),
        .pred_o    (pred_o),
        .history_o (history_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic load_cases();
        int          fd;
        int          c;
        int          code;
        int          v_a;
        int          v_b;
        int          v_p;
        logic [31:0] v_pc;
        logic [31:0] v_inst;
        logic [31:0] v_tgt;
        n_cases = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open case file %s", CASE_FILE);
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != -1 && c != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (c == "L" || c == "U") begin
                    if (c == "L") begin
                        code = $fscanf(fd, "%h %h %d %d %h %d", v_pc, v_inst, v_a, v_b, v_tgt, v_p);
                    end else begin
                        v_inst = '0;
                        code = $fscanf(fd, "%h %d %d %d %h", v_pc, v_a, v_b, v_p, v_tgt);
                        code = code + 1;  // one field fewer than a lookup
                    end
                    if (code != 6) begin
                        $display("malformed line in case file after case %0d", n_cases);
                        errors++;
                    end else if (n_cases >= MAX_CASES) begin
                        $display("case file holds more than %0d cases", MAX_CASES);
                        errors++;
                    end else begin
                        cases[n_cases] = '{c[7:0], v_pc, v_inst, v_a[0], v_b[0], v_p[1:0], v_tgt};
                        n_cases++;
                    end
                end else if (c != " " && c != "\n" && c != "\t" && c != "\r") begin
                    $display("unexpected character in case file after case %0d", n_cases);
                    errors++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        load_ok = (errors == 0) && (n_cases > 0);
    endtask

    task automatic run_lookup(input case_t tc);
        logic [31:0] rnd;
        logic [31:0] pc;
        logic [31:0] exp_target;
        pc         = tc.pc;
        exp_target = tc.target;
        if (!tc.flag_a) begin  // non-control, fetch address is random
            rnd        = $random(seed);
            pc         = {rnd[31:2], 2'b00};
            exp_target = pc + 32'd4;
        end
        @(posedge clk);
        #1;
        update_i     = '0;
        fetch_i.pc   = pc;
        fetch_i.inst = tc.inst;
        #4;
        checks += 4;
        assert (pred_o.is_ctrl == tc.flag_a) else begin
            $display("Mismatch at %0t: pc %h is_ctrl %0b, expected %0b",
                     $time, pc, pred_o.is_ctrl, tc.flag_a);
            errors++;
        end
        assert (pred_o.taken == tc.flag_b) else begin
            $display("Mismatch at %0t: pc %h taken %0b, expected %0b",
                     $time, pc, pred_o.taken, tc.flag_b);
            errors++;
        end
        assert (pred_o.target == exp_target) else begin
            $display("Mismatch at %0t: pc %h target %h, expected %h",
                     $time, pc, pred_o.target, exp_target);
            errors++;
        end
        assert (pred_o.provider == tc.prov) else begin
            $display("Mismatch at %0t: pc %h provider %0d, expected %0d",
                     $time, pc, pred_o.provider, tc.prov);
            errors++;
        end
    endtask

    task automatic run_update(input case_t tc);
        @(posedge clk);
        #1;
        update_i.valid    = 1'b1;
        update_i.taken    = tc.flag_a;
        update_i.correct  = tc.flag_b;
        update_i.provider = bpu_pkg::provider_e'(tc.prov);
        update_i.pc       = tc.pc;
        update_i.target   = tc.target;
        update_i.history  = hist_model;  // snapshot as fetch saw it
        @(posedge clk);
        #1;
        update_i.valid = 1'b0;
        hist_model     = {hist_model[bpu_pkg::HIST_LEN-2:0], tc.flag_a};
        checks++;
        assert (history_o == hist_model) else begin
            $display("Mismatch at %0t: history %h, expected %h", $time, history_o, hist_model);
            errors++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        fetch_i     = '0;
        update_i    = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        seed        = 81;
        hist_model  = '0;
        cycle_limit = 50 + 4 * MAX_CASES;
        load_cases();
        cycle_limit = 50 + 4 * n_cases;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        checks++;
        assert (history_o == '0) else begin
            $display("Mismatch at %0t: history %h after reset, expected 0", $time, history_o);
            errors++;
        end
        if (load_ok) begin
            for (int i = 0; i < n_cases; i++) begin
                if (cases[i].kind == "L") begin
                    run_lookup(cases[i]);
                end else begin
                    run_update(cases[i]);
                end
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && load_ok) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
